//--- logic/pt_walk_config.svh
// Width and count macros for the page table walker
// Levels, entry and line geometry, page and line address sizes
`ifndef PT_WALK_CONFIG_SVH
`define PT_WALK_CONFIG_SVH

// ========================================
// Table geometry
// ========================================

// Index bits per level, 512 entries in each table page
`define PT_IDX_WIDTH 9

// Levels of indirection in the table
`define PT_MAX_DEPTH 4

// Bits to hold a depth of 0 .. PT_MAX_DEPTH-1
`define PT_DEPTH_BITS 2

// Virtual page index is one index per level
`define PT_VA_PAGE_BITS (`PT_IDX_WIDTH * `PT_MAX_DEPTH)

// ========================================
// Memory lines and entries
// ========================================

// Memory line and entry widths
`define PT_LINE_BITS 512
`define PT_WORD_BITS 64

// Entries per line and the index bits that select one
`define PT_WORDS_PER_LINE (`PT_LINE_BITS / `PT_WORD_BITS)
`define PT_WORD_SEL_BITS 3

// Byte offset inside a 64 byte line
`define PT_LINE_BYTE_BITS 6

// Line address and the line bits inside a 4 KB page
`define PT_LINE_ADDR_BITS 42
`define PT_PAGE_OFFSET_BITS 6

// Physical 4 KB page index
`define PT_PA_PAGE_BITS 36

`endif

//--- logic/pt_walk_pkg.sv
// Shared types of the page table walker
// Level indices, pages, line addresses, lines and the entry layout
`default_nettype none

`include "pt_walk_config.svh"

package pt_walk_pkg;

    // ========================================
    // Walk indices
    // ========================================

    // One level index into a table page
    typedef logic [`PT_IDX_WIDTH-1:0] t_pt_idx;

    // Current depth of a walk, 0 is the root
    typedef logic [`PT_DEPTH_BITS-1:0] t_pt_depth;

    // All level indices, root level in the top slot
    typedef t_pt_idx [`PT_MAX_DEPTH-1:0] t_pt_idx_vec;

    // ========================================
    // Addresses and data
    // ========================================

    typedef logic [`PT_VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [`PT_PA_PAGE_BITS-1:0] t_pa_page;
    typedef logic [`PT_LINE_ADDR_BITS-1:0] t_line_addr;

    // A memory line seen as its entry words
    typedef logic [`PT_WORDS_PER_LINE-1:0][`PT_WORD_BITS-1:0] t_line;

    // Low status bits of an entry
    typedef struct packed
    {
        // No translation, also set in a blank all-ones entry
        logic error;
        // Entry holds the translation itself
        logic terminal;
    } t_pte_status;

    // Field view of an entry
    typedef struct packed
    {
        logic [`PT_WORD_BITS-`PT_LINE_ADDR_BITS-`PT_LINE_BYTE_BITS-1:0] upper;
        t_line_addr line_addr;
        logic [`PT_LINE_BYTE_BITS-$bits(t_pte_status)-1:0] spare;
        t_pte_status status;
    } t_pte_fields;

    // Entry word, raw as read or split into fields
    typedef union packed
    {
        logic [`PT_WORD_BITS-1:0] raw;
        t_pte_fields fields;
    } t_pte;

endpackage

`default_nettype wire

//--- logic/pte_fetch_if.sv
// Fetch interface between the walk FSM and the entry fetch unit
`timescale 1ns/10ps
`default_nettype none

interface pte_fetch_if;

    import pt_walk_pkg::*;

    // ========================================
    // Request side, from the walk FSM
    // ========================================

    // Held high until the entry has come back
    logic fetch_req;
    // Table page of the current level
    t_pa_page fetch_page;
    // Index into that page
    t_pt_idx fetch_idx;

    // ========================================
    // Answer side, from the fetch unit
    // ========================================

    // One cycle pulse with the decoded entry
    logic fetch_done;
    t_pte_status fetch_status;
    // Page the entry points at
    t_pa_page fetch_next_page;

    modport ctrl
    (
        output fetch_req, fetch_page, fetch_idx,
        input  fetch_done, fetch_status, fetch_next_page
    );

    modport fetch
    (
        input  fetch_req, fetch_page, fetch_idx,
        output fetch_done, fetch_status, fetch_next_page
    );

endinterface

`default_nettype wire

//--- logic/pt_walk_ctrl.sv
// Walk FSM of the page table walker
// Enable level, index vector and depth tracking, TLB fill and error flag
`timescale 1ns/10ps
`default_nettype none

`include "pt_walk_config.svh"

module pt_walk_ctrl
(
    input  logic clk,
    input  logic reset,

    // Configuration levels
    input  pt_walk_pkg::t_pa_page table_base,
    input  logic table_base_valid,
    input  logic mode_enable,

    // TLB miss request
    input  logic req_en,
    input  pt_walk_pkg::t_va_page req_va,
    output logic req_rdy,

    // TLB fill
    input  logic fill_rdy,
    output logic fill_en,
    output pt_walk_pkg::t_va_page fill_va,
    output pt_walk_pkg::t_pa_page fill_pa,
    output logic fill_big_page,

    // Status
    output logic not_present,
    output logic busy,

    // Entry fetch unit
    pte_fetch_if.ctrl fetch
);

    import pt_walk_pkg::*;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_FETCH,
        S_EVAL,
        S_DONE,
        S_ERROR
    } t_walk_state;

    t_walk_state state;

    // Both configuration levels, registered
    logic enabled;

    // Walk payload
    t_va_page walk_va;
    t_pt_idx_vec idx_vec;
    t_pt_depth depth;
    // Table page while walking, translated page once done
    t_pa_page cur_page;
    t_pte_status status_q;

    logic req_accept;
    logic at_last_level;
    logic walk_fail;
    logic walk_descend;

    // ========================================
    // Handshakes and decisions
    // ========================================

    // One walk at a time
    assign req_rdy = enabled && (state == S_IDLE);
    assign req_accept = req_en && req_rdy;
    assign busy = (state != S_IDLE);

    assign at_last_level = (depth == t_pt_depth'(`PT_MAX_DEPTH - 1));

    // Error bit, or no translation found at the deepest level
    assign walk_fail = status_q.error || (!status_q.terminal && at_last_level);
    assign walk_descend = !walk_fail && !status_q.terminal;

    // Current level's index sits in the top slot
    assign fetch.fetch_req = (state == S_FETCH);
    assign fetch.fetch_page = cur_page;
    assign fetch.fetch_idx = idx_vec[`PT_MAX_DEPTH-1];

    // ========================================
    // State transitions
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            enabled <= 1'b0;
            not_present <= 1'b0;
        end
        else
        begin
            enabled <= table_base_valid && mode_enable;

            case (state)
                S_IDLE:
                begin
                    if (req_accept)
                    begin
                        state <= S_FETCH;
                    end
                end

                S_FETCH:
                begin
                    // Wait for the entry of this level
                    if (fetch.fetch_done)
                    begin
                        state <= S_EVAL;
                    end
                end

                S_EVAL:
                begin
                    if (walk_fail)
                    begin
                        state <= S_ERROR;
                    end
                    else if (status_q.terminal)
                    begin
                        state <= S_DONE;
                    end
                    else
                    begin
                        state <= S_FETCH;
                    end
                end

                S_DONE:
                begin
                    // Outputs hold until the TLB takes them
                    if (fill_en)
                    begin
                        state <= S_IDLE;
                    end
                end

                S_ERROR:
                begin
                    // Stuck here, flag stays up until reset
                    not_present <= 1'b1;
                end

                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Walk payload
    // ========================================

    always_ff @(posedge clk)
    begin
        // New walk always starts at the root
        if (req_accept)
        begin
            walk_va <= req_va;
            idx_vec <= t_pt_idx_vec'(req_va);
            depth <= '0;
            cur_page <= table_base;
        end

        // Entry arrived, keep its status and the page it points at
        if ((state == S_FETCH) && fetch.fetch_done)
        begin
            status_q <= fetch.fetch_status;
            cur_page <= fetch.fetch_next_page;
        end

        // Move down one level
        if ((state == S_EVAL) && walk_descend)
        begin
            depth <= depth + t_pt_depth'(1);
            for (int i = `PT_MAX_DEPTH - 1; i > 0; i--)
            begin
                idx_vec[i] <= idx_vec[i-1];
            end
            idx_vec[0] <= '0;
        end
    end

    // ========================================
    // TLB fill
    // ========================================

    assign fill_en = (state == S_DONE) && fill_rdy;
    assign fill_va = walk_va;
    assign fill_pa = cur_page;
    // Anything that ends above the last level maps a big page
    assign fill_big_page = !at_last_level;

endmodule

`default_nettype wire

//--- logic/pte_fetch.sv
// Entry fetch unit of the page table walker
// Line read issue, registered response, word select and entry decode
`timescale 1ns/10ps
`default_nettype none

`include "pt_walk_config.svh"

module pte_fetch
(
    input  logic clk,
    input  logic reset,

    // Line read request
    input  logic read_rdy,
    output logic read_en,
    output pt_walk_pkg::t_line_addr read_addr,

    // Line read response
    input  logic read_data_en,
    input  pt_walk_pkg::t_line read_data,

    // Walk FSM side
    pte_fetch_if.fetch fetch
);

    import pt_walk_pkg::*;

    typedef enum logic [1:0]
    {
        F_IDLE,
        F_READ,
        F_WAIT
    } t_fetch_state;

    t_fetch_state state;

    // Response register stage
    logic rsp_en_q;
    t_line rsp_line_q;

    // Entry picked from the line
    logic [`PT_WORD_SEL_BITS-1:0] word_sel;
    t_pte pte;

    // ========================================
    // Read request
    // ========================================

    // Line inside the page from the high index bits
    assign read_addr = {fetch.fetch_page,
                        fetch.fetch_idx[`PT_IDX_WIDTH-1 -: `PT_PAGE_OFFSET_BITS]};

    // Fires only while memory can take it
    assign read_en = (state == F_READ) && read_rdy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= F_IDLE;
        end
        else
        begin
            case (state)
                F_IDLE:
                begin
                    // Request level drops right after each answer
                    if (fetch.fetch_req)
                    begin
                        state <= F_READ;
                    end
                end

                F_READ:
                begin
                    if (read_en)
                    begin
                        state <= F_WAIT;
                    end
                end

                F_WAIT:
                begin
                    if (fetch.fetch_done)
                    begin
                        state <= F_IDLE;
                    end
                end

                default:
                begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Response stage
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_en_q <= 1'b0;
        end
        else
        begin
            rsp_en_q <= read_data_en;
        end
        rsp_line_q <= read_data;
    end

    // Low index bits pick the entry inside the line
    assign word_sel = fetch.fetch_idx[`PT_WORD_SEL_BITS-1:0];
    assign pte.raw = rsp_line_q[word_sel];

    assign fetch.fetch_done = rsp_en_q && (state == F_WAIT);
    assign fetch.fetch_status = pte.fields.status;
    // Page is the pointed line address without its in-page bits
    assign fetch.fetch_next_page =
        pte.fields.line_addr[`PT_LINE_ADDR_BITS-1 -: `PT_PA_PAGE_BITS];

endmodule

`default_nettype wire

//--- logic/pt_walk_top.sv
// Top level of the page table walker
// Joins the walk FSM and the entry fetch unit through the fetch interface
`timescale 1ns/10ps
`default_nettype none

module pt_walk_top
(
    input  logic clk,
    input  logic reset,

    // Configuration levels
    input  pt_walk_pkg::t_pa_page table_base,
    input  logic table_base_valid,
    input  logic mode_enable,

    // TLB miss request
    input  logic req_en,
    input  pt_walk_pkg::t_va_page req_va,
    output logic req_rdy,

    // Line read request
    input  logic read_rdy,
    output logic read_en,
    output pt_walk_pkg::t_line_addr read_addr,

    // Line read response
    input  logic read_data_en,
    input  pt_walk_pkg::t_line read_data,

    // TLB fill
    input  logic fill_rdy,
    output logic fill_en,
    output pt_walk_pkg::t_va_page fill_va,
    output pt_walk_pkg::t_pa_page fill_pa,
    output logic fill_big_page,

    // Status
    output logic not_present,
    output logic busy
);

    // FSM to fetch unit, one entry request at a time
    pte_fetch_if fetch_bus();

    pt_walk_ctrl i_ctrl
    (
        .clk              (clk),
        .reset            (reset),
        .table_base       (table_base),
        .table_base_valid (table_base_valid),
        .mode_enable      (mode_enable),
        .req_en           (req_en),
        .req_va           (req_va),
        .req_rdy          (req_rdy),
        .fill_rdy         (fill_rdy),
        .fill_en          (fill_en),
        .fill_va          (fill_va),
        .fill_pa          (fill_pa),
        .fill_big_page    (fill_big_page),
        .not_present      (not_present),
        .busy             (busy),
        .fetch            (fetch_bus.ctrl)
    );

    pte_fetch i_fetch
    (
        .clk          (clk),
        .reset        (reset),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .fetch        (fetch_bus.fetch)
    );

endmodule

`default_nettype wire

//--- test/pt_walk_assert.sv
// Concurrent checks on the walker handshakes, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module pt_walk_assert
(
    input logic clk,
    input logic reset,
    input logic read_en,
    input logic read_rdy,
    input logic fill_en,
    input logic fill_rdy,
    input logic not_present
);

    // A read fires only while memory can take it
    read_needs_rdy: assert property (@(posedge clk) disable iff (reset)
        read_en |-> read_rdy)
        else $error("read_en high while read_rdy is low");

    // Fill strobe follows the TLB ready level
    fill_needs_rdy: assert property (@(posedge clk) disable iff (reset)
        fill_en |-> fill_rdy)
        else $error("fill_en high while fill_rdy is low");

    // Sticky error flag, only reset clears it
    np_sticky: assert property (@(posedge clk) disable iff (reset)
        not_present |=> not_present)
        else $error("not_present fell without reset");

    // A walk is either still reading or filling
    read_fill_apart: assert property (@(posedge clk) disable iff (reset)
        !(read_en && fill_en))
        else $error("read_en and fill_en high together");

endmodule

bind pt_walk_top pt_walk_assert i_assert
(
    .clk         (clk),
    .reset       (reset),
    .read_en     (read_en),
    .read_rdy    (read_rdy),
    .fill_en     (fill_en),
    .fill_rdy    (fill_rdy),
    .not_present (not_present)
);

`default_nettype wire

//--- test/pt_walk_tb.sv
// Testbench of the page table walker
// Clock, reset, line memory model, reference walk, checks, watchdog, summary
`timescale 1ns/10ps
`default_nettype none

`include "pt_walk_config.svh"

module pt_walk_tb;

    import pt_walk_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_WALKS = 13;
    localparam int MAX_WALK_CYCLES = 300;
    // Walks plus resets and the enable test
    localparam int WATCHDOG_CYCLES = NUM_WALKS * MAX_WALK_CYCLES + 400;

    logic clk = 1'b0;
    logic reset = 1'b1;
    t_pa_page table_base = '0;
    logic table_base_valid = 1'b0;
    logic mode_enable = 1'b0;
    logic req_en = 1'b0;
    t_va_page req_va = '0;
    logic req_rdy;
    logic read_rdy = 1'b0;
    logic read_en;
    t_line_addr read_addr;
    logic read_data_en = 1'b0;
    t_line read_data = '0;
    logic fill_rdy = 1'b0;
    logic fill_en;
    t_va_page fill_va;
    t_pa_page fill_pa;
    logic fill_big_page;
    logic not_present;
    logic busy;

    int seed = 43528;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errors = 0;
    string test_name;

    // Line memory, lines never written read as a blank pattern
    t_line mem [t_line_addr];
    logic mem_pending = 1'b0;
    int mem_delay = 0;
    t_line_addr mem_addr = '0;
    int rsp_count = 0;

    // Expected result of the walk in flight
    t_va_page exp_va;
    t_pa_page exp_pa;
    logic exp_big;
    logic exp_err;
    int ends = 0;
    logic np_q = 1'b0;

    pt_walk_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Memory model
    // ========================================

    // Error bit set in every blank word, rest marks the address
    function automatic t_line blank_line(input t_line_addr addr);
        t_line line;
        for (int w = 0; w < `PT_WORDS_PER_LINE; w++)
        begin
            line[w] = {19'(w), addr, 3'b010};
        end
        return line;
    endfunction

    function automatic t_line mem_read(input t_line_addr addr);
        return mem.exists(addr) ? mem[addr] : blank_line(addr);
    endfunction

    task automatic store_entry(input t_line_addr addr, input logic [2:0] w,
                               input logic [`PT_WORD_BITS-1:0] word);
        t_line line;
        line = mem_read(addr);
        line[w] = word;
        mem[addr] = line;
    endtask

    // Random read_rdy, one answer 1 to 8 cycles after each read
    always @(posedge clk)
    begin
        if (reset)
        begin
            read_rdy <= 1'b0;
            read_data_en <= 1'b0;
            mem_pending = 1'b0;
        end
        else
        begin
            read_data_en <= 1'b0;
            read_rdy <= (($random(seed) & 3) != 0);
            if (read_en)
            begin
                mem_pending = 1'b1;
                mem_addr = read_addr;
                mem_delay = 1 + ($random(seed) & 7);
            end
            else if (mem_pending)
            begin
                mem_delay = mem_delay - 1;
                if (mem_delay == 0)
                begin
                    read_data_en <= 1'b1;
                    read_data <= mem_read(mem_addr);
                    rsp_count <= rsp_count + 1;
                    mem_pending = 1'b0;
                end
            end
        end
    end

    // ========================================
    // Table build and reference walk
    // ========================================

    // Chain of entries from the root down to end_depth
    task automatic build_path(input t_va_page va, input int end_depth,
                              input logic [1:0] end_status);
        t_pa_page page;
        t_pa_page next;
        t_pt_idx idx;
        logic [1:0] status;
        page = table_base;
        for (int d = 0; d <= end_depth; d++)
        begin
            idx = va[(`PT_MAX_DEPTH-1-d)*`PT_IDX_WIDTH +: `PT_IDX_WIDTH];
            next = t_pa_page'({$random(seed), $random(seed)});
            status = (d == end_depth) ? end_status : 2'b00;
            store_entry({page, idx[`PT_IDX_WIDTH-1 -: `PT_PAGE_OFFSET_BITS]},
                        idx[`PT_WORD_SEL_BITS-1:0],
                        {16'($random(seed)), next, 6'($random(seed)),
                         4'($random(seed)), status});
            page = next;
        end
    endtask

    function automatic void ref_walk(input t_va_page va, input t_pa_page base,
                                     output t_pa_page pa, output logic big,
                                     output logic err, output int levels);
        t_pa_page page;
        t_pt_idx idx;
        t_line line;
        logic [`PT_WORD_BITS-1:0] word;
        logic ended;
        page = base;
        pa = '0;
        big = 1'b0;
        err = 1'b0;
        levels = 0;
        ended = 1'b0;
        for (int d = 0; d < `PT_MAX_DEPTH; d++)
        begin
            if (!ended)
            begin
                idx = va[(`PT_MAX_DEPTH-1-d)*`PT_IDX_WIDTH +: `PT_IDX_WIDTH];
                line = mem_read({page, idx[`PT_IDX_WIDTH-1 -: `PT_PAGE_OFFSET_BITS]});
                word = line[idx[`PT_WORD_SEL_BITS-1:0]];
                // Page is the pointed line address without its in-page bits
                page = word[`PT_LINE_BYTE_BITS+`PT_LINE_ADDR_BITS-1 -: `PT_PA_PAGE_BITS];
                levels = d + 1;
                // Bit 1 error, bit 0 terminal
                if (word[1] || (!word[0] && (d == `PT_MAX_DEPTH - 1)))
                begin
                    err = 1'b1;
                    ended = 1'b1;
                end
                else if (word[0])
                begin
                    pa = page;
                    big = (d != `PT_MAX_DEPTH - 1);
                    ended = 1'b1;
                end
            end
        end
    endfunction

    // ========================================
    // Compare tasks and result checker
    // ========================================

    task automatic check_page(input string name, input t_pa_page got, input t_pa_page exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_va(input string name, input t_va_page got, input t_va_page exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Fill or error flag ends a walk
    always @(posedge clk)
    begin
        if (reset)
        begin
            np_q <= 1'b0;
        end
        else
        begin
            np_q <= not_present;
            if (fill_en)
            begin
                if (exp_err)
                begin
                    $display("[ERROR] fill_en came on a walk that should have failed");
                    errors++;
                end
                check_page("fill_pa", fill_pa, exp_pa);
                check_va("fill_va", fill_va, exp_va);
                check_flag("fill_big_page", fill_big_page, exp_big);
                ends <= ends + 1;
            end
            if (not_present && !np_q)
            begin
                if (!exp_err)
                begin
                    $display("[ERROR] not_present rose on a walk that should have succeeded");
                    errors++;
                end
                ends <= ends + 1;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_errors)
        begin
            $display("[test %0d] %s: PASS", tests_run, test_name);
        end
        else
        begin
            tests_failed++;
            $display("[test %0d] %s: FAIL, %0d errors", tests_run, test_name,
                     errors - test_errors);
        end
    endtask

    // One walk, fill_rdy held low a while when stall is set
    task automatic run_walk(input t_va_page va, input int end_depth,
                            input logic [1:0] end_status, input logic stall);
        int start_ends;
        int start_rsp;
        int levels;
        t_va_page held_va;
        t_pa_page held_pa;
        logic held_big;
        build_path(va, end_depth, end_status);
        ref_walk(va, table_base, exp_pa, exp_big, exp_err, levels);
        exp_va = va;
        start_ends = ends;
        start_rsp = rsp_count;
        @(posedge clk);
        while (!req_rdy)
        begin
            @(posedge clk);
        end
        req_en <= 1'b1;
        req_va <= va;
        fill_rdy <= !stall;
        @(posedge clk);
        req_en <= 1'b0;
        if (stall)
        begin
            // Last entry back, then evaluate, then the done state
            while (rsp_count < start_rsp + levels)
            begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            held_va = fill_va;
            held_pa = fill_pa;
            held_big = fill_big_page;
            repeat (6)
            begin
                @(posedge clk);
                check_flag("fill_en", fill_en, 1'b0);
                check_va("fill_va held", fill_va, held_va);
                check_page("fill_pa held", fill_pa, held_pa);
                check_flag("fill_big_page held", fill_big_page, held_big);
            end
            fill_rdy <= 1'b1;
        end
        while (ends == start_ends)
        begin
            @(posedge clk);
        end
        // Idle again after a fill, stuck in the error state after a failure
        check_flag("busy", busy, exp_err);
    endtask

    initial
    begin
        @(posedge clk);
        table_base <= t_pa_page'({$random(seed), $random(seed)});
        table_base_valid <= 1'b1;
        apply_reset();

        start_test("enable gating");
        repeat (20)
        begin
            @(posedge clk);
            check_flag("req_rdy", req_rdy, 1'b0);
        end
        mode_enable <= 1'b1;
        for (int i = 0; (i < 4) && !req_rdy; i++)
        begin
            @(posedge clk);
        end
        check_flag("req_rdy", req_rdy, 1'b1);
        finish_test();

        start_test("four level walks");
        for (int i = 0; i < 4; i++)
        begin
            run_walk(t_va_page'({$random(seed), $random(seed)}), 3, 2'b01, 1'b0);
        end
        finish_test();

        start_test("big page walks");
        for (int i = 0; i < 3; i++)
        begin
            run_walk(t_va_page'({$random(seed), $random(seed)}), 2, 2'b01, 1'b0);
        end
        finish_test();

        start_test("read and fill stalls");
        for (int i = 0; i < 3; i++)
        begin
            run_walk(t_va_page'({$random(seed), $random(seed)}), 3 - (i % 2), 2'b01, 1'b1);
        end
        finish_test();

        start_test("not present and recovery");
        run_walk(t_va_page'({$random(seed), $random(seed)}), 1, 2'b10, 1'b0);
        repeat (5) @(posedge clk);
        check_flag("not_present", not_present, 1'b1);
        apply_reset();
        check_flag("not_present", not_present, 1'b0);
        check_flag("busy", busy, 1'b0);
        run_walk(t_va_page'({$random(seed), $random(seed)}), 3, 2'b00, 1'b0);
        apply_reset();
        check_flag("not_present", not_present, 1'b0);
        run_walk(t_va_page'({$random(seed), $random(seed)}), 3, 2'b01, 1'b0);
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Ends a run that stopped making progress
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, a walk did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- pt_walk_top.f
+incdir+logic
logic/pt_walk_pkg.sv
logic/pte_fetch_if.sv
logic/pt_walk_ctrl.sv
logic/pte_fetch.sv
logic/pt_walk_top.sv
test/pt_walk_assert.sv
test/pt_walk_tb.sv

//--- Makefile
# Verilator build and run of the page table walker testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert -j 0 -f pt_walk_top.f \
		--top-module pt_walk_tb -Mdir obj_dir
	-./obj_dir/Vpt_walk_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
